// File: project.f
+incdir+src
src/soc_pkg.sv
src/soc_bus_decoder.sv
src/soc_l2_mem.sv
src/soc_ctrl_regs.sv
src/soc_wb_to_apb.sv
src/soc_top.sv
sim/tb_soc.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_soc -f project.f -o tb_soc_sim \
  || { echo "Verilator build failed"; exit 1; }
out="$(./obj_dir/tb_soc_sim)"
echo "$out"
echo "$out" | grep -qx "All checks passed" && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: sim/soc_testdata.txt
# name op(R/W) address write_data select expected_read_data expected_error (all hex)
# On W lines to the exit or counter-enable register the expected column is the output value
l2_rst_first      R 80000000 0000000000000000 ff 0000000000000000 0
l2_rst_last       R 800007f8 0000000000000000 ff 0000000000000000 0
l2_rst_mid        R 80000400 0000000000000000 ff 0000000000000000 0
l2_wr_full        W 80000008 1122334455667788 ff 0000000000000000 0
l2_rd_full        R 80000008 0000000000000000 ff 1122334455667788 0
l2_wr_low         W 80000008 aaaaaaaaaaaaaaaa 0f 0000000000000000 0
l2_rd_low         R 80000008 0000000000000000 ff 11223344aaaaaaaa 0
l2_wr_b7          W 80000008 cc00000000000000 80 0000000000000000 0
l2_rd_b7          R 80000008 0000000000000000 ff cc223344aaaaaaaa 0
l2_wr_sparse      W 80000100 ffeeddccbbaa9988 a5 0000000000000000 0
l2_rd_sparse      R 80000100 0000000000000000 ff ff00dd0000aa0088 0
l2_wr_nosel       W 80000100 0123456789abcdef 00 0000000000000000 0
l2_rd_nosel       R 80000100 0000000000000000 ff ff00dd0000aa0088 0
l2_wr_top         W 800007f8 deadbeefcafef00d ff 0000000000000000 0
l2_rd_top         R 800007f8 0000000000000000 ff deadbeefcafef00d 0
l2_rd_neighbor    R 80000000 0000000000000000 ff 0000000000000000 0
l2_rd_past_end    R 80000800 0000000000000000 ff 0000000000000000 1
ctrl_rd_exit_rst  R d0000000 0000000000000000 ff 0000000000000000 0
ctrl_wr_exit      W d0000000 0000000000000001 ff 0000000000000001 0
ctrl_rd_exit      R d0000000 0000000000000000 ff 0000000000000001 0
ctrl_wr_exit_b1   W d0000000 ffffffffffffff00 02 000000000000ff01 0
ctrl_rd_exit_b1   R d0000000 0000000000000000 ff 000000000000ff01 0
ctrl_wr_cnt       W d0000008 ffffffffffffffff 01 00000000000000ff 0
ctrl_rd_cnt       R d0000008 0000000000000000 ff 00000000000000ff 0
ctrl_rd_base      R d0000010 0000000000000000 ff 0000000080000000 0
ctrl_rd_end       R d0000018 0000000000000000 ff 0000000080000800 0
ctrl_wr_base      W d0000010 0000000012345678 ff 0000000000000000 0
ctrl_rd_base_kept R d0000010 0000000000000000 ff 0000000080000000 0
ctrl_rd_hole      R d0000020 0000000000000000 ff 0000000000000000 0
ctrl_wr_hole      W d0000ff8 ffffffffffffffff ff 0000000000000000 0
ctrl_rd_hole_top  R d0000ff8 0000000000000000 ff 0000000000000000 0
ctrl_rd_exit_kept R d0000000 0000000000000000 ff 000000000000ff01 0
uart_wr_0         W c0000000 ffffffff00000041 ff 0000000000000000 0
uart_wr_c         W c000000c 1234567887654321 ff 0000000000000000 0
uart_rd_0         R c0000000 0000000000000000 ff 00000000a5a50000 0
uart_rd_14        R c0000014 0000000000000000 ff 00000000a5a50014 0
uart_rd_ff8       R c0000ff8 0000000000000000 ff 00000000a5a50ff8 0
uart_rd_slverr    R c0000ffc 0000000000000000 ff 0000000000000000 1
uart_wr_slverr    W c0000ffc 00000000000000aa ff 0000000000000000 1
uart_wr_after_err W c0000800 00000000cafebabe ff 0000000000000000 0
unmapped_zero     R 00000000 0000000000000000 ff 0000000000000000 1
unmapped_wr_9     W 90000000 0123456789abcdef ff 0000000000000000 1
unmapped_uart_end R c0001000 0000000000000000 ff 0000000000000000 1
unmapped_ctrl_end R d0001000 0000000000000000 ff 0000000000000000 1
unmapped_top      R fffffff8 0000000000000000 ff 0000000000000000 1
l2_rd_after_err   R 80000008 0000000000000000 ff cc223344aaaaaaaa 0

// File: sim/tb_soc.sv
// Testbench for the bus fabric; replays the access list from sim/soc_testdata.txt against the DUT
`timescale 1ns/100ps
`default_nettype none

`include "soc_defs.svh"

module tb_soc;

  localparam logic [31:0] ExitAddr  = `SOC_CTRL_BASE + 32'(soc_pkg::CTRL_EXIT);
  localparam logic [31:0] CntEnAddr = `SOC_CTRL_BASE + 32'(soc_pkg::CTRL_CNT_EN);

  logic                     clk = 1'b0;
  logic                     arst_n;
  logic                     wb_cyc;
  logic                     wb_stb;
  logic                     wb_we;
  logic [`SOC_ADDR_W-1:0]   wb_adr;
  logic [`SOC_DATA_W-1:0]   wb_dat_w;
  logic [`SOC_DATA_W/8-1:0] wb_sel;
  logic [`SOC_DATA_W-1:0]   wb_dat_r;
  logic                     wb_ack;
  logic                     wb_err;
  logic [`SOC_DATA_W-1:0]   exit_code;
  logic [`SOC_DATA_W-1:0]   hw_cnt_en;
  logic                     psel;
  logic                     penable;
  logic                     pwrite;
  logic [`SOC_APB_W-1:0]    paddr;
  logic [`SOC_APB_W-1:0]    pwdata;
  logic [`SOC_APB_W-1:0]    prdata;
  logic                     pready;
  logic                     pslverr;

  // Access list
  string       t_name[$];
  logic        t_write[$];
  logic [31:0] t_adr[$];
  logic [63:0] t_wdat[$];
  logic [7:0]  t_sel[$];
  logic [63:0] t_exp[$];
  logic        t_err[$];

  int unsigned wait_left;
  logic [31:0] rng_state = 32'd26963;
  logic [31:0] last_paddr;
  logic [31:0] last_pwdata;
  int          apb_writes = 0;
  int          error_cnt = 0;
  int unsigned cycle_cnt = 0;
  int unsigned cycle_limit = 50;

  always #5 clk = ~clk;

  soc_top i_dut (
    .clk_i          (clk      ),
    .arst_n_i       (arst_n   ),
    .wb_cyc_i       (wb_cyc   ),
    .wb_stb_i       (wb_stb   ),
    .wb_we_i        (wb_we    ),
    .wb_adr_i       (wb_adr   ),
    .wb_dat_i       (wb_dat_w ),
    .wb_sel_i       (wb_sel   ),
    .wb_dat_o       (wb_dat_r ),
    .wb_ack_o       (wb_ack   ),
    .wb_err_o       (wb_err   ),
    .exit_o         (exit_code),
    .hw_cnt_en_o    (hw_cnt_en),
    .uart_psel_o    (psel     ),
    .uart_penable_o (penable  ),
    .uart_pwrite_o  (pwrite   ),
    .uart_paddr_o   (paddr    ),
    .uart_pwdata_o  (pwdata   ),
    .uart_prdata_i  (prdata   ),
    .uart_pready_i  (pready   ),
    .uart_pslverr_i (pslverr  )
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (expected !== actual) begin
      error_cnt++;
      $display("FAIL %s expected 0x%016h actual 0x%016h", name, expected, actual);
    end
  endtask

  //////////////////////////////
  // APB responder model
  //////////////////////////////

  always begin
    @(posedge clk);
    #1;
    if (psel && !penable) begin
      rng_state = xorshift(rng_state);
      wait_left = rng_state % 4;
    end else if (psel && penable && !pready) begin
      if (wait_left == 0) begin
        pready  = 1'b1;
        prdata  = paddr ^ 32'hA5A5_0000;
        pslverr = (paddr == 32'h0000_0FFC);
        if (pwrite) begin
          last_paddr  = paddr;
          last_pwdata = pwdata;
          apb_writes++;
        end
      end else begin
        wait_left--;
      end
    end else begin
      pready  = 1'b0;
      pslverr = 1'b0;
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      error_cnt++;
      $display("Run timed out after %0d cycles", cycle_cnt);
      $display("Errors: %0d", error_cnt);
      $display("Checks failed");
      $finish;
    end
  end

  //////////////////////////////
  // Wishbone master
  //////////////////////////////

  task automatic bus_access(input logic we, input logic [31:0] adr, input logic [63:0] wdat,
                            input logic [7:0] sel, output logic [63:0] rdat,
                            output logic err);
    logic done;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    wb_sel   = sel;
    done     = 1'b0;
    rdat     = '0;
    err      = 1'b0;
    while (!done) begin
      @(posedge clk);
      #1;
      if (wb_ack && wb_err) begin
        error_cnt++;
        $display("Ack and err both high at address 0x%08h", adr);
      end
      if (wb_ack || wb_err) begin
        done = 1'b1;
        rdat = wb_dat_r;
        err  = wb_err;
      end
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(posedge clk);
    #1;
    if (wb_ack || wb_err) begin
      error_cnt++;
      $display("Response at address 0x%08h lasted more than one cycle", adr);
    end
  endtask

  initial begin
    int          fd;
    int          n;
    int          writes_before;
    string       line;
    string       name;
    string       op;
    logic [31:0] adr;
    logic [63:0] wdat;
    logic [7:0]  sel;
    logic [63:0] exp_dat;
    logic        exp_err;
    logic [63:0] rdat;
    logic        err;
    logic        uart_hit;

    arst_n   = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    wb_sel   = '0;
    prdata   = '0;
    pready   = 1'b0;
    pslverr  = 1'b0;

    fd = $fopen("sim/soc_testdata.txt", "r");
    if (fd == 0) begin
      error_cnt++;
      $display("Cannot open the access list sim/soc_testdata.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 0 && line.substr(0, 0) != "#") begin
          n = $sscanf(line, "%s %s %h %h %h %h %h", name, op, adr, wdat, sel, exp_dat, exp_err);
          if (n == 7 && (op == "R" || op == "W")) begin
            t_name.push_back(name);
            t_write.push_back(op == "W");
            t_adr.push_back(adr);
            t_wdat.push_back(wdat);
            t_sel.push_back(sel);
            t_exp.push_back(exp_dat);
            t_err.push_back(exp_err);
          end else if (n > 0) begin
            error_cnt++;
            $display("Malformed line in the access list: %s", line);
          end
        end
      end
      $fclose(fd);
    end
    cycle_limit = 20 * t_name.size() + 50;

    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;
    @(posedge clk);
    #1;
    check("rst_exit", 64'h0, exit_code);
    check("rst_cnt_en", 64'h0, hw_cnt_en);
    check("rst_ack", 64'h0, 64'(wb_ack));
    check("rst_err", 64'h0, 64'(wb_err));
    check("rst_psel", 64'h0, 64'(psel));
    check("rst_penable", 64'h0, 64'(penable));

    for (int i = 0; i < t_name.size(); i++) begin
      writes_before = apb_writes;
      bus_access(t_write[i], t_adr[i], t_wdat[i], t_sel[i], rdat, err);
      check({t_name[i], "_err"}, 64'(t_err[i]), 64'(err));
      // Only writes into the UART window become APB writes
      uart_hit = (t_adr[i] - `SOC_UART_BASE) < `SOC_UART_LEN;
      check({t_name[i], "_apb_writes"}, 64'(writes_before + int'(t_write[i] && uart_hit)),
            64'(apb_writes));
      if (!t_err[i]) begin
        if (!t_write[i]) begin
          check({t_name[i], "_rdata"}, t_exp[i], rdat);
        end else if (t_adr[i] == ExitAddr) begin
          check({t_name[i], "_exit"}, t_exp[i], exit_code);
        end else if (t_adr[i] == CntEnAddr) begin
          check({t_name[i], "_cnt_en"}, t_exp[i], hw_cnt_en);
        end else if (uart_hit) begin
          check({t_name[i], "_paddr"}, 64'(t_adr[i] - `SOC_UART_BASE), 64'(last_paddr));
          check({t_name[i], "_pwdata"}, 64'(t_wdat[i][31:0]), 64'(last_pwdata));
        end
      end
    end

    $display("Errors: %0d", error_cnt);
    if (error_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src/soc_bus_decoder.sv
// Wishbone address decoder; steers stb to one target and merges ack, err and read data
`timescale 1ns/100ps
`default_nettype none

`include "soc_defs.svh"

module soc_bus_decoder (
  input  wire                  clk_i,
  input  wire                  arst_n_i,
  input  wire                  wb_cyc_i,
  input  wire                  wb_stb_i,
  input  wire soc_pkg::addr_t  wb_adr_i,
  output logic                 wb_ack_o,
  output logic                 wb_err_o,
  output soc_pkg::data_t       wb_dat_o,
  output logic                 mem_stb_o,
  output logic                 ctrl_stb_o,
  output logic                 apb_stb_o,
  input  wire                  mem_ack_i,
  input  wire                  ctrl_ack_i,
  input  wire                  apb_ack_i,
  input  wire                  apb_err_i,
  input  wire soc_pkg::data_t  mem_dat_i,
  input  wire soc_pkg::data_t  ctrl_dat_i,
  input  wire soc_pkg::data_t  apb_dat_i
);

  //////////////////////////////
  // Address decode
  //////////////////////////////

  soc_pkg::addr_t   dram_off;
  soc_pkg::addr_t   uart_off;
  soc_pkg::addr_t   ctrl_off;
  soc_pkg::target_e tgt;
  logic             req;
  logic             err_q;

  // Offsets wrap below the base, so one unsigned compare per window
  assign dram_off = wb_adr_i - soc_pkg::addr_t'(`SOC_DRAM_BASE);
  assign uart_off = wb_adr_i - soc_pkg::addr_t'(`SOC_UART_BASE);
  assign ctrl_off = wb_adr_i - soc_pkg::addr_t'(`SOC_CTRL_BASE);

  always_comb begin
    tgt = soc_pkg::NONE;
    if (dram_off < soc_pkg::addr_t'(`SOC_DRAM_LEN)) begin
      tgt = soc_pkg::L2MEM;
    end else if (uart_off < soc_pkg::addr_t'(`SOC_UART_LEN)) begin
      tgt = soc_pkg::UART;
    end else if (ctrl_off < soc_pkg::addr_t'(`SOC_CTRL_LEN)) begin
      tgt = soc_pkg::CTRL;
    end
  end

  assign req        = wb_cyc_i & wb_stb_i;
  assign mem_stb_o  = req && (tgt == soc_pkg::L2MEM);
  assign apb_stb_o  = req && (tgt == soc_pkg::UART);
  assign ctrl_stb_o = req && (tgt == soc_pkg::CTRL);

  //////////////////////////////
  // Responses
  //////////////////////////////

  // Unmapped access, single err pulse
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= req && (tgt == soc_pkg::NONE) && !err_q;
    end
  end

  assign wb_ack_o = mem_ack_i | ctrl_ack_i | apb_ack_i;
  assign wb_err_o = err_q | apb_err_i;

  always_comb begin
    case (tgt)
      soc_pkg::L2MEM: wb_dat_o = mem_dat_i;
      soc_pkg::UART:  wb_dat_o = apb_dat_i;
      soc_pkg::CTRL:  wb_dat_o = ctrl_dat_i;
      default:        wb_dat_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: src/soc_ctrl_regs.sv
// Control register block for exit code, counter enable and read-only DRAM bounds
`timescale 1ns/100ps
`default_nettype none

`include "soc_defs.svh"

module soc_ctrl_regs (
  input  wire                  clk_i,
  input  wire                  arst_n_i,
  input  wire                  stb_i,
  input  wire                  we_i,
  input  wire soc_pkg::addr_t  adr_i,
  input  wire soc_pkg::data_t  dat_i,
  input  wire soc_pkg::sel_t   sel_i,
  output soc_pkg::data_t       dat_o,
  output logic                 ack_o,
  output soc_pkg::data_t       exit_o,
  output soc_pkg::data_t       hw_cnt_en_o
);

  localparam soc_pkg::data_t DramBase = soc_pkg::data_t'(`SOC_DRAM_BASE);
  localparam soc_pkg::data_t DramEnd  = DramBase + soc_pkg::data_t'(`SOC_DRAM_LEN);

  logic [soc_pkg::CTRL_OFF_W-1:0] off;
  soc_pkg::data_t                 exit_q;
  soc_pkg::data_t                 cnt_en_q;
  soc_pkg::data_t                 rdata_d;
  soc_pkg::data_t                 rdata_q;
  logic                           access;
  logic                           ack_q;

  assign off    = adr_i[soc_pkg::CTRL_OFF_W-1:0];
  assign access = stb_i && !ack_q;

  //////////////////////////////
  // Writable registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_q   <= '0;
      cnt_en_q <= '0;
      ack_q    <= 1'b0;
    end else begin
      ack_q <= access;
      if (access && we_i) begin
        case (off)
          soc_pkg::CTRL_EXIT:   exit_q   <= soc_pkg::merge_bytes(exit_q, dat_i, sel_i);
          soc_pkg::CTRL_CNT_EN: cnt_en_q <= soc_pkg::merge_bytes(cnt_en_q, dat_i, sel_i);
          // DRAM bounds and holes are read-only
          default: ;
        endcase
      end
    end
  end

  //////////////////////////////
  // Read path
  //////////////////////////////

  always_comb begin
    case (off)
      soc_pkg::CTRL_EXIT:      rdata_d = exit_q;
      soc_pkg::CTRL_CNT_EN:    rdata_d = cnt_en_q;
      soc_pkg::CTRL_DRAM_BASE: rdata_d = DramBase;
      soc_pkg::CTRL_DRAM_END:  rdata_d = DramEnd;
      default:                 rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      rdata_q <= rdata_d;
    end
  end

  assign dat_o       = rdata_q;
  assign ack_o       = ack_q;
  assign exit_o      = exit_q;
  assign hw_cnt_en_o = cnt_en_q;

endmodule

`default_nettype wire

// File: src/soc_defs.svh
// Memory map, bus widths and L2 depth; include wherever these constants are needed
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

//////////////////////////////
// Bus widths
//////////////////////////////

`define SOC_ADDR_W 32
`define SOC_DATA_W 64
`define SOC_APB_W 32

//////////////////////////////
// Memory map
//////////////////////////////

`define SOC_DRAM_BASE 32'h8000_0000
`define SOC_UART_BASE 32'hC000_0000
`define SOC_CTRL_BASE 32'hD000_0000

`define SOC_UART_LEN 32'h0000_1000
`define SOC_CTRL_LEN 32'h0000_1000

// L2 depth in 64-bit words
`define SOC_L2_WORDS 256

// DRAM region spans the whole L2
`define SOC_DRAM_LEN (`SOC_L2_WORDS * (`SOC_DATA_W / 8))

`endif

// File: src/soc_l2_mem.sv
// L2 word memory behind the decoder, byte-select writes and one-cycle registered ack
`timescale 1ns/100ps
`default_nettype none

`include "soc_defs.svh"

module soc_l2_mem #(
  parameter int unsigned NumWords = `SOC_L2_WORDS
) (
  input  wire                  clk_i,
  input  wire                  arst_n_i,
  input  wire                  stb_i,
  input  wire                  we_i,
  input  wire soc_pkg::addr_t  adr_i,
  input  wire soc_pkg::data_t  dat_i,
  input  wire soc_pkg::sel_t   sel_i,
  output soc_pkg::data_t       dat_o,
  output logic                 ack_o
);

  localparam int unsigned OffW = $clog2(`SOC_DATA_W / 8);
  localparam int unsigned IdxW = $clog2(NumWords);

  soc_pkg::data_t  mem_q [NumWords];
  soc_pkg::data_t  rdata_q;
  logic [IdxW-1:0] idx;
  logic            access;
  logic            ack_q;

  // Word index, upper address bits drop out
  assign idx    = adr_i[OffW +: IdxW];
  assign access = stb_i && !ack_q;

  // Memory comes up cleared
  initial begin
    for (int i = 0; i < NumWords; i++) begin
      mem_q[i] = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      if (we_i) begin
        mem_q[idx] <= soc_pkg::merge_bytes(mem_q[idx], dat_i, sel_i);
      end else begin
        rdata_q <= mem_q[idx];
      end
    end
  end

  // Ack once per strobe
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  assign dat_o = rdata_q;
  assign ack_o = ack_q;

endmodule

`default_nettype wire

// File: src/soc_pkg.sv
// Bus types, target encoding and control register offsets shared by the fabric RTL
`default_nettype none

`include "soc_defs.svh"

package soc_pkg;

  typedef logic [`SOC_ADDR_W-1:0]   addr_t;
  typedef logic [`SOC_DATA_W-1:0]   data_t;
  typedef logic [`SOC_DATA_W/8-1:0] sel_t;

  typedef enum logic [1:0] {
    L2MEM = 2'd0,
    UART  = 2'd1,
    CTRL  = 2'd2,
    NONE  = 2'd3
  } target_e;

  // Offset bits inside the control window
  localparam int unsigned CTRL_OFF_W = $clog2(`SOC_CTRL_LEN);

  localparam logic [CTRL_OFF_W-1:0] CTRL_EXIT      = 'h00;
  localparam logic [CTRL_OFF_W-1:0] CTRL_CNT_EN    = 'h08;
  localparam logic [CTRL_OFF_W-1:0] CTRL_DRAM_BASE = 'h10;
  localparam logic [CTRL_OFF_W-1:0] CTRL_DRAM_END  = 'h18;

  // Byte-wise merge of write data into an old word
  function automatic data_t merge_bytes(data_t old_val, data_t wdat, sel_t sel);
    data_t res;
    res = old_val;
    for (int b = 0; b < $bits(sel_t); b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = wdat[8*b +: 8];
      end
    end
    return res;
  endfunction

endpackage

`default_nettype wire

// File: src/soc_top.sv
// Bus fabric top; Wishbone port in, L2, control registers and UART APB port out
`timescale 1ns/100ps
`default_nettype none

`include "soc_defs.svh"

module soc_top (
  input  wire                    clk_i,
  input  wire                    arst_n_i,
  input  wire                    wb_cyc_i,
  input  wire                    wb_stb_i,
  input  wire                    wb_we_i,
  input  wire soc_pkg::addr_t    wb_adr_i,
  input  wire soc_pkg::data_t    wb_dat_i,
  input  wire soc_pkg::sel_t     wb_sel_i,
  output soc_pkg::data_t         wb_dat_o,
  output logic                   wb_ack_o,
  output logic                   wb_err_o,
  output soc_pkg::data_t         exit_o,
  output soc_pkg::data_t         hw_cnt_en_o,
  output logic                   uart_psel_o,
  output logic                   uart_penable_o,
  output logic                   uart_pwrite_o,
  output logic [`SOC_APB_W-1:0]  uart_paddr_o,
  output logic [`SOC_APB_W-1:0]  uart_pwdata_o,
  input  wire  [`SOC_APB_W-1:0]  uart_prdata_i,
  input  wire                    uart_pready_i,
  input  wire                    uart_pslverr_i
);

  logic           mem_stb;
  logic           mem_ack;
  soc_pkg::data_t mem_dat;
  logic           ctrl_stb;
  logic           ctrl_ack;
  soc_pkg::data_t ctrl_dat;
  logic           apb_stb;
  logic           apb_ack;
  logic           apb_err;
  soc_pkg::data_t apb_dat;

  //////////////////////////////
  // Decoder
  //////////////////////////////

  soc_bus_decoder i_decoder (
    .clk_i      (clk_i   ),
    .arst_n_i   (arst_n_i),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_adr_i   (wb_adr_i),
    .wb_ack_o   (wb_ack_o),
    .wb_err_o   (wb_err_o),
    .wb_dat_o   (wb_dat_o),
    .mem_stb_o  (mem_stb ),
    .ctrl_stb_o (ctrl_stb),
    .apb_stb_o  (apb_stb ),
    .mem_ack_i  (mem_ack ),
    .ctrl_ack_i (ctrl_ack),
    .apb_ack_i  (apb_ack ),
    .apb_err_i  (apb_err ),
    .mem_dat_i  (mem_dat ),
    .ctrl_dat_i (ctrl_dat),
    .apb_dat_i  (apb_dat )
  );

  //////////////////////////////
  // Targets
  //////////////////////////////

  soc_l2_mem #(
    .NumWords (`SOC_L2_WORDS)
  ) i_l2_mem (
    .clk_i    (clk_i   ),
    .arst_n_i (arst_n_i),
    .stb_i    (mem_stb ),
    .we_i     (wb_we_i ),
    .adr_i    (wb_adr_i),
    .dat_i    (wb_dat_i),
    .sel_i    (wb_sel_i),
    .dat_o    (mem_dat ),
    .ack_o    (mem_ack )
  );

  soc_ctrl_regs i_ctrl_regs (
    .clk_i       (clk_i      ),
    .arst_n_i    (arst_n_i   ),
    .stb_i       (ctrl_stb   ),
    .we_i        (wb_we_i    ),
    .adr_i       (wb_adr_i   ),
    .dat_i       (wb_dat_i   ),
    .sel_i       (wb_sel_i   ),
    .dat_o       (ctrl_dat   ),
    .ack_o       (ctrl_ack   ),
    .exit_o      (exit_o     ),
    .hw_cnt_en_o (hw_cnt_en_o)
  );

  // UART sits on the APB side
  soc_wb_to_apb i_wb_to_apb (
    .clk_i     (clk_i         ),
    .arst_n_i  (arst_n_i      ),
    .stb_i     (apb_stb       ),
    .we_i      (wb_we_i       ),
    .adr_i     (wb_adr_i      ),
    .dat_i     (wb_dat_i      ),
    .dat_o     (apb_dat       ),
    .ack_o     (apb_ack       ),
    .err_o     (apb_err       ),
    .psel_o    (uart_psel_o   ),
    .penable_o (uart_penable_o),
    .pwrite_o  (uart_pwrite_o ),
    .paddr_o   (uart_paddr_o  ),
    .pwdata_o  (uart_pwdata_o ),
    .prdata_i  (uart_prdata_i ),
    .pready_i  (uart_pready_i ),
    .pslverr_i (uart_pslverr_i)
  );

endmodule

`default_nettype wire

// File: src/soc_wb_to_apb.sv
// Wishbone to APB bridge; each bus access becomes one APB setup and access phase
`timescale 1ns/100ps
`default_nettype none

`include "soc_defs.svh"

module soc_wb_to_apb (
  input  wire                    clk_i,
  input  wire                    arst_n_i,
  input  wire                    stb_i,
  input  wire                    we_i,
  input  wire soc_pkg::addr_t    adr_i,
  input  wire soc_pkg::data_t    dat_i,
  output soc_pkg::data_t         dat_o,
  output logic                   ack_o,
  output logic                   err_o,
  output logic                   psel_o,
  output logic                   penable_o,
  output logic                   pwrite_o,
  output logic [`SOC_APB_W-1:0]  paddr_o,
  output logic [`SOC_APB_W-1:0]  pwdata_o,
  input  wire  [`SOC_APB_W-1:0]  prdata_i,
  input  wire                    pready_i,
  input  wire                    pslverr_i
);

  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    SETUP  = 2'd1,
    ACCESS = 2'd2
  } state_e;

  state_e                state_q;
  logic                  start;
  logic                  done;
  logic                  ack_q;
  logic                  err_q;
  logic                  pwrite_q;
  logic [`SOC_APB_W-1:0] paddr_q;
  logic [`SOC_APB_W-1:0] pwdata_q;
  logic [`SOC_APB_W-1:0] prdata_q;

  // No restart while the previous response is still on the bus
  assign start = (state_q == IDLE) && stb_i && !ack_q && !err_q;
  assign done  = (state_q == ACCESS) && pready_i;

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      ack_q   <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      ack_q <= done && !pslverr_i;
      err_q <= done && pslverr_i;
      case (state_q)
        IDLE: begin
          if (start) begin
            state_q <= SETUP;
          end
        end
        SETUP:   state_q <= ACCESS;
        ACCESS: begin
          if (pready_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Request captured once, held through the transfer
  always_ff @(posedge clk_i) begin
    if (start) begin
      pwrite_q <= we_i;
      paddr_q  <= adr_i - soc_pkg::addr_t'(`SOC_UART_BASE);
      pwdata_q <= dat_i[`SOC_APB_W-1:0];
    end
    if (done) begin
      prdata_q <= prdata_i;
    end
  end

  assign psel_o    = (state_q != IDLE);
  assign penable_o = (state_q == ACCESS);
  assign pwrite_o  = pwrite_q;
  assign paddr_o   = paddr_q;
  assign pwdata_o  = pwdata_q;

  assign dat_o = soc_pkg::data_t'(prdata_q);
  assign ack_o = ack_q;
  assign err_o = err_q;

endmodule

`default_nettype wire
